// File: build.f
design/cpu_pkg.sv
design/pipeline_control.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/cpu_top.sv
tests/cpu_sva.sv
tests/cpu_tb.sv

// File: Makefile
TOP = cpu_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: tests/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

  import cpu_pkg::*;

  localparam logic [15:0] RESET_PC   = 16'h0000;
  localparam int          MAX_CYCLES = 300;                    // Budget per test
  localparam int          TIMEOUT_NS = 6 * MAX_CYCLES * 100;   // Six tests at 100 ns

  logic        clk;
  logic        rst;
  logic [15:0] imem_addr;
  logic [15:0] imem_data;
  logic        dmem_en;
  logic        dmem_wr;
  logic [15:0] dmem_addr;
  logic [15:0] dmem_wdata;
  logic [15:0] dmem_rdata;
  logic        hlt;
  logic [15:0] pc;

  logic [15:0] rom  [256];     // Program, HLT everywhere else
  logic [15:0] dram [32768];   // Word RAM seen by the DUT
  logic [15:0] mram [32768];   // Copy owned by the reference model
  logic [15:0] mreg [16];
  logic [31:0] exp_q [$];      // Expected stores as {addr, data}
  logic [31:0] exp_word;
  logic [15:0] halt_pc;
  int          prog_len;
  int          exp_loads;
  int          loads_seen;
  int          errors;
  int          tests_run;
  int          tests_failed;
  integer      seed;

  cpu_top #(.RESET_PC(RESET_PC)) dut (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_en    (dmem_en),
    .dmem_wr    (dmem_wr),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_rdata (dmem_rdata),
    .hlt        (hlt),
    .pc         (pc)
  );

  always #50 clk = ~clk;

  ////////////////////
  // Memory models
  ////////////////////
  assign imem_data  = rom[imem_addr[8:1]];     // Same-cycle fetch
  assign dmem_rdata = dram[dmem_addr[15:1]];   // Same-cycle load

  always @(posedge clk) begin
    if (dmem_en && dmem_wr)
      dram[dmem_addr[15:1]] <= dmem_wdata;
  end

  function automatic logic [15:0] fill_word(input logic [14:0] idx);
    return {idx[7:0], idx[14:8], 1'b1} ^ 16'hc3a5;  // Every index bit shows up
  endfunction

  function automatic logic [15:0] reg_instr(input logic [3:0] op, input logic [3:0] rd,
                                            input logic [3:0] rs, input logic [3:0] rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic logic [15:0] imm_instr(input logic [3:0] op, input logic [3:0] rd,
                                            input logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  task automatic check(input logic cond, input string msg);
    assert (cond) else begin
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic clear_program();
    for (int k = 0; k < 256; k++)
      rom[k] = 16'hf000;
    prog_len = 0;
  endtask

  task automatic add_instr(input logic [15:0] w);
    rom[prog_len] = w;
    prog_len++;
  endtask

  task automatic load_ram();
    for (int k = 0; k < 32768; k++) begin
      dram[k] <= fill_word(15'(k));
      mram[k] = fill_word(15'(k));
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////
  // Runs the program in order up to HLT, collecting stores and loads
  task automatic run_model();
    logic [15:0] w;
    logic [15:0] mpc;
    logic [15:0] addr;
    logic [15:0] val;
    logic        wr;
    int          steps;
    for (int k = 0; k < 16; k++)
      mreg[k] = '0;
    exp_q.delete();
    exp_loads = 0;
    mpc = RESET_PC;
    steps = 0;
    while (steps < 512) begin
      w = rom[mpc[8:1]];
      if (w[15:12] == OP_HLT)
        break;
      addr = mreg[w[7:4]] + {{11{w[3]}}, w[3:0], 1'b0};  // Base plus word offset
      val  = '0;
      wr   = 1'b1;
      case (w[15:12])
        OP_ADD: val = mreg[w[7:4]] + mreg[w[3:0]];
        OP_SUB: val = mreg[w[7:4]] - mreg[w[3:0]];
        OP_XOR: val = mreg[w[7:4]] ^ mreg[w[3:0]];
        OP_LLB: val = {mreg[w[11:8]][15:8], w[7:0]};
        OP_LHB: val = {w[7:0], mreg[w[11:8]][7:0]};
        OP_LW: begin
          val = mram[addr[15:1]];
          exp_loads++;
        end
        OP_SW: begin
          mram[addr[15:1]] = mreg[w[11:8]];
          exp_q.push_back({addr, mreg[w[11:8]]});
          wr = 1'b0;
        end
        default: wr = 1'b0;               // Reserved, nothing written
      endcase
      if (wr && (w[11:8] != 4'd0))
        mreg[w[11:8]] = val;              // r0 stays zero
      mpc = mpc + 16'd2;
      steps++;
    end
    halt_pc = mpc;
  endtask

  // Store and load monitor, values settle well before the falling edge
  always @(negedge clk) begin
    if (dmem_en === 1'b1 && dmem_wr === 1'b1) begin
      if (exp_q.size() == 0) begin
        check(1'b0, $sformatf("unexpected store %h <- %h", dmem_addr, dmem_wdata));
      end else begin
        exp_word = exp_q.pop_front();
        check(dmem_addr == exp_word[31:16],
              $sformatf("store address %h, expected %h", dmem_addr, exp_word[31:16]));
        check(dmem_wdata == exp_word[15:0],
              $sformatf("store data %h, expected %h", dmem_wdata, exp_word[15:0]));
      end
    end else if (dmem_en === 1'b1) begin
      loads_seen++;
    end
  end

  ////////////////////
  // Test sequencing
  ////////////////////
  task automatic run_test(input string name);
    int start_err;
    int cycles;
    start_err = errors;
    load_ram();
    run_model();
    loads_seen = 0;
    rst = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    check(pc == RESET_PC, $sformatf("%s: pc %h after reset", name, pc));
    check(hlt == 1'b0, $sformatf("%s: hlt high after reset", name));
    check(dmem_en == 1'b0, $sformatf("%s: dmem_en high after reset", name));
    cycles = 0;
    while (hlt !== 1'b1 && cycles < MAX_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (hlt !== 1'b1) begin
      $display("%s: hlt never rose within %0d cycles", name, MAX_CYCLES);
      errors++;
    end
    repeat (20) begin                    // Nothing may run past HLT
      @(negedge clk);
      check(pc == halt_pc, $sformatf("%s: pc %h, HLT is at %h", name, pc, halt_pc));
    end
    check(exp_q.size() == 0, $sformatf("%s: %0d stores missing", name, exp_q.size()));
    check(loads_seen == exp_loads,
          $sformatf("%s: %0d loads seen, expected %0d", name, loads_seen, exp_loads));
    tests_run++;
    if (errors != start_err)
      tests_failed++;
    $display("%-8s %s after %0d cycles", name, (errors == start_err) ? "ok" : "errors", cycles);
  endtask

  initial begin
    int          pick;
    logic [31:0] r;
    logic [3:0]  rd;
    logic [3:0]  rs;
    logic [3:0]  rt;
    clk          = 1'b0;
    rst          = 1'b1;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    loads_seen   = 0;
    seed         = 32'hc0bc;
    clear_program();
    load_ram();

    // Only the final SW touches memory
    clear_program();
    add_instr(imm_instr(OP_LLB, 4'd1, 8'h21));
    add_instr(imm_instr(OP_LLB, 4'd2, 8'h10));
    add_instr(reg_instr(OP_ADD, 4'd3, 4'd1, 4'd2));
    add_instr(reg_instr(OP_SW, 4'd3, 4'd0, 4'd2));
    run_test("reset");

    // Producers at distance 1, 2 and 3, plus a write to r0
    clear_program();
    add_instr(imm_instr(OP_LLB, 4'd1, 8'h05));
    add_instr(imm_instr(OP_LLB, 4'd2, 8'h03));
    add_instr(reg_instr(OP_ADD, 4'd3, 4'd1, 4'd2));
    add_instr(reg_instr(OP_SUB, 4'd4, 4'd3, 4'd1));
    add_instr(reg_instr(OP_XOR, 4'd5, 4'd4, 4'd2));
    add_instr(reg_instr(OP_ADD, 4'd6, 4'd5, 4'd3));
    add_instr(reg_instr(OP_ADD, 4'd0, 4'd1, 4'd2));
    add_instr(reg_instr(OP_SUB, 4'd7, 4'd6, 4'd0));
    add_instr(reg_instr(OP_XOR, 4'd1, 4'd7, 4'd4));
    add_instr(reg_instr(OP_SW, 4'd1, 4'd0, 4'd1));
    add_instr(reg_instr(OP_SW, 4'd7, 4'd0, 4'd2));
    add_instr(reg_instr(OP_SW, 4'd0, 4'd0, 4'd3));
    run_test("alu_fwd");

    // Same register rebuilt byte by byte, back to back
    clear_program();
    add_instr(imm_instr(OP_LLB, 4'd1, 8'hab));
    add_instr(imm_instr(OP_LHB, 4'd1, 8'hcd));
    add_instr(imm_instr(OP_LLB, 4'd1, 8'hef));
    add_instr(reg_instr(OP_SW, 4'd1, 4'd0, 4'd0));
    add_instr(imm_instr(OP_LHB, 4'd2, 8'h12));
    add_instr(imm_instr(OP_LLB, 4'd2, 8'h34));
    add_instr(imm_instr(OP_LHB, 4'd2, 8'h56));
    add_instr(reg_instr(OP_SW, 4'd2, 4'd0, 4'd1));
    add_instr(imm_instr(OP_LLB, 4'd3, 8'h80));
    add_instr(reg_instr(OP_SW, 4'd3, 4'd0, 4'hf));   // Negative offset
    run_test("bytes");

    // Load feeding an ALU op, store data and a store base
    clear_program();
    add_instr(imm_instr(OP_LLB, 4'd1, 8'h40));
    add_instr(reg_instr(OP_LW, 4'd2, 4'd1, 4'd1));
    add_instr(reg_instr(OP_ADD, 4'd3, 4'd2, 4'd2));
    add_instr(reg_instr(OP_SW, 4'd3, 4'd1, 4'd2));
    add_instr(reg_instr(OP_LW, 4'd4, 4'd1, 4'd3));
    add_instr(reg_instr(OP_SW, 4'd4, 4'd1, 4'd4));
    add_instr(reg_instr(OP_LW, 4'd5, 4'd0, 4'd5));
    add_instr(reg_instr(OP_SW, 4'd1, 4'd5, 4'd0));
    run_test("load_use");

    // 40 random instructions over r0 to r7
    clear_program();
    for (int n = 0; n < 40; n++) begin
      r    = $random(seed);
      pick = int'(r[31:16] % 16'd7);
      rd   = {1'b0, r[6:4]};
      rs   = {1'b0, r[10:8]};
      rt   = (pick == 3 || pick == 4) ? r[15:12] : {1'b0, r[14:12]};  // Offset or reg
      case (pick)
        0:       add_instr(reg_instr(OP_ADD, rd, rs, rt));
        1:       add_instr(reg_instr(OP_SUB, rd, rs, rt));
        2:       add_instr(reg_instr(OP_XOR, rd, rs, rt));
        3:       add_instr(reg_instr(OP_LW, rd, rs, rt));
        4:       add_instr(reg_instr(OP_SW, rd, rs, rt));
        5:       add_instr(imm_instr(OP_LLB, rd, r[23:16]));
        default: add_instr(imm_instr(OP_LHB, rd, r[23:16]));
      endcase
    end
    run_test("random");

    // Stores placed after HLT must never reach memory
    clear_program();
    add_instr(imm_instr(OP_LLB, 4'd1, 8'h77));
    add_instr(reg_instr(OP_SW, 4'd1, 4'd0, 4'd1));
    add_instr(16'hf000);
    add_instr(reg_instr(OP_SW, 4'd1, 4'd0, 4'd2));
    add_instr(reg_instr(OP_SW, 4'd1, 4'd0, 4'd3));
    run_test("halt");

    $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog sized for six tests at the full cycle budget
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: tests/cpu_sva.sv
`timescale 1ns/1ps

module cpu_sva (
  input logic        clk,
  input logic        rst,
  input logic        dmem_en,
  input logic        dmem_wr,
  input logic        hlt,
  input logic [15:0] pc
);

  // Write strobe is only a qualifier of the enable
  a_wr_has_en : assert property (@(posedge clk) disable iff (rst) dmem_wr |-> dmem_en)
    else $error("dmem_wr high without dmem_en");

  // First cycle out of reset has an empty memory stage
  a_quiet_after_rst : assert property (@(posedge clk) $fell(rst) |-> !dmem_en)
    else $error("data access in the first cycle after reset");

  ////////////////////
  // Halt behavior
  ////////////////////
  a_hlt_sticky : assert property (@(posedge clk) disable iff (rst) hlt |=> hlt)
    else $error("hlt dropped before reset");

  a_pc_parked : assert property (@(posedge clk) disable iff (rst) hlt |=> $stable(pc))
    else $error("pc moved while halted");

  a_pc_even : assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0)
    else $error("pc is odd");  // Fetch is word aligned

endmodule

bind cpu_top cpu_sva u_sva (
  .clk     (clk),
  .rst     (rst),
  .dmem_en (dmem_en),
  .dmem_wr (dmem_wr),
  .hlt     (hlt),
  .pc      (pc)
);

// File: design/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
  parameter logic [cpu_pkg::DATA_W-1:0] RESET_PC = '0
) (
  input  logic                       clk,
  input  logic                       rst,         // Synchronous, active high
  output logic [cpu_pkg::DATA_W-1:0] imem_addr,   // Instruction port
  input  logic [cpu_pkg::DATA_W-1:0] imem_data,
  output logic                       dmem_en,     // Data port
  output logic                       dmem_wr,
  output logic [cpu_pkg::DATA_W-1:0] dmem_addr,
  output logic [cpu_pkg::DATA_W-1:0] dmem_wdata,
  input  logic [cpu_pkg::DATA_W-1:0] dmem_rdata,
  output logic                       hlt,
  output logic [cpu_pkg::DATA_W-1:0] pc
);

  import cpu_pkg::*;

  if_id_t  if_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  wb_t     wb;        // Shared by register file and forwarding
  logic    load_use;
  logic    halt_seen;

  assign imem_addr = pc;

  ////////////////////
  // Stages
  ////////////////////
  pipeline_control #(.RESET_PC(RESET_PC)) u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .imem_data (instr_u'(imem_data)),
    .load_use  (load_use),
    .halt_seen (halt_seen),
    .pc        (pc),
    .if_id     (if_id)
  );

  decode_stage u_decode (
    .clk       (clk),
    .rst       (rst),
    .if_id     (if_id),
    .wb        (wb),
    .id_ex     (id_ex),
    .load_use  (load_use),
    .halt_seen (halt_seen)
  );

  execute_stage u_execute (
    .clk    (clk),
    .rst    (rst),
    .id_ex  (id_ex),
    .wb     (wb),
    .ex_mem (ex_mem)
  );

  memory_stage u_memory (
    .clk        (clk),
    .rst        (rst),
    .ex_mem     (ex_mem),
    .dmem_rdata (dmem_rdata),
    .dmem_en    (dmem_en),
    .dmem_wr    (dmem_wr),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .wb         (wb),
    .hlt        (hlt)
  );

endmodule

`default_nettype wire

// File: design/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
  input  logic                       clk,
  input  logic                       rst,
  input  cpu_pkg::ex_mem_t           ex_mem,
  input  logic [cpu_pkg::DATA_W-1:0] dmem_rdata,  // Same-cycle read data
  output logic                       dmem_en,     // One cycle per LW or SW
  output logic                       dmem_wr,
  output logic [cpu_pkg::DATA_W-1:0] dmem_addr,
  output logic [cpu_pkg::DATA_W-1:0] dmem_wdata,
  output cpu_pkg::wb_t               wb,
  output logic                       hlt          // Sticky until reset
);

  import cpu_pkg::*;

  mem_wb_t mem_wb;
  logic    hlt_hold;

  ////////////////////
  // Data port
  ////////////////////
  assign dmem_en    = ex_mem.mem_en;
  assign dmem_wr    = ex_mem.mem_wr;
  assign dmem_addr  = ex_mem.result;
  assign dmem_wdata = ex_mem.store_data;

  // MEM/WB register with halt latch
  always_ff @(posedge clk) begin
    mem_wb.result    <= ex_mem.result;
    mem_wb.load_data <= dmem_rdata;
    mem_wb.rd        <= ex_mem.rd;
    if (rst) begin
      mem_wb.reg_wr     <= 1'b0;
      mem_wb.mem_to_reg <= 1'b0;
      mem_wb.halt       <= 1'b0;
      hlt_hold          <= 1'b0;
    end else begin
      mem_wb.reg_wr     <= ex_mem.reg_wr;
      mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
      mem_wb.halt       <= ex_mem.halt;
      if (mem_wb.halt)
        hlt_hold <= 1'b1;
    end
  end

  ////////////////////
  // Write-back select
  ////////////////////
  assign wb.we   = mem_wb.reg_wr;
  assign wb.rd   = mem_wb.rd;
  assign wb.data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.result;

  assign hlt = mem_wb.halt | hlt_hold;  // High from the cycle HLT reaches MEM/WB

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic             clk,
  input  logic             rst,
  input  cpu_pkg::id_ex_t  id_ex,
  input  cpu_pkg::wb_t     wb,      // Oldest forwarding source
  output cpu_pkg::ex_mem_t ex_mem
);

  import cpu_pkg::*;

  logic [DATA_W-1:0] op_a;       // Forwarded operand 1
  logic [DATA_W-1:0] op_b;       // Forwarded operand 2 and store data
  logic [DATA_W-1:0] alu_out;
  ex_mem_t           ex_mem_d;

  ////////////////////
  // Forwarding
  ////////////////////
  // EX/MEM is newer than write-back and wins
  function automatic logic [DATA_W-1:0] fwd(input logic [REG_ADDR_W-1:0] src,
                                           input logic [DATA_W-1:0]     val);
    if (src == '0)
      return val;                               // r0 reads zero already
    if (ex_mem.reg_wr && (ex_mem.rd == src))
      return ex_mem.result;
    if (wb.we && (wb.rd == src))
      return wb.data;
    return val;
  endfunction

  always_comb begin
    op_a = fwd(id_ex.src1, id_ex.op1);
    op_b = fwd(id_ex.src2, id_ex.op2);
  end

  ////////////////////
  // ALU
  ////////////////////
  always_comb begin
    unique case (id_ex.alu_op)
      ALU_ADD:  alu_out = op_a + op_b;
      ALU_SUB:  alu_out = op_a - op_b;
      ALU_XOR:  alu_out = op_a ^ op_b;
      ALU_LLB:  alu_out = {op_b[15:8], id_ex.imm[7:0]};   // High byte kept
      ALU_LHB:  alu_out = {id_ex.imm[7:0], op_b[7:0]};    // Low byte kept
      ALU_ADDR: alu_out = op_a + id_ex.imm;               // Offset pre-scaled in decode
      default:  alu_out = op_a + op_b;
    endcase
  end

  always_comb begin
    ex_mem_d.result     = alu_out;
    ex_mem_d.store_data = op_b;
    ex_mem_d.rd         = id_ex.rd;
    ex_mem_d.reg_wr     = id_ex.reg_wr;
    ex_mem_d.mem_en     = id_ex.mem_en;
    ex_mem_d.mem_wr     = id_ex.mem_wr;
    ex_mem_d.mem_to_reg = id_ex.mem_to_reg;
    ex_mem_d.halt       = id_ex.halt;
  end

  // EX/MEM register
  always_ff @(posedge clk) begin
    ex_mem <= ex_mem_d;
    if (rst) begin
      ex_mem.reg_wr     <= 1'b0;
      ex_mem.mem_en     <= 1'b0;   // No data access out of reset
      ex_mem.mem_wr     <= 1'b0;
      ex_mem.mem_to_reg <= 1'b0;
      ex_mem.halt       <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic             clk,
  input  logic             rst,
  input  cpu_pkg::if_id_t  if_id,
  input  cpu_pkg::wb_t     wb,         // Write-back into the register file
  output cpu_pkg::id_ex_t  id_ex,
  output logic             load_use,   // Load in ID/EX feeds IF/ID
  output logic             halt_seen   // IF/ID holds HLT
);

  import cpu_pkg::*;

  instr_u            ins;
  id_ex_t            id_ex_d;      // Decoded word before bubble insertion
  logic [DATA_W-1:0] rd_data1;     // Register file read ports
  logic [DATA_W-1:0] rd_data2;
  logic              halt_passed;  // HLT already sent down the pipe
  logic              bubble;

  assign ins = if_id.instr;

  ////////////////////
  // Field decode
  ////////////////////
  always_comb begin
    id_ex_d            = '0;
    id_ex_d.src1       = ins.r.rs;
    id_ex_d.src2       = ins.r.rt;
    id_ex_d.rd         = ins.r.rd;
    id_ex_d.alu_op     = ALU_ADD;
    unique case (ins.r.opcode)
      OP_ADD: id_ex_d.reg_wr = 1'b1;
      OP_SUB: begin
        id_ex_d.alu_op = ALU_SUB;
        id_ex_d.reg_wr = 1'b1;
      end
      OP_XOR: begin
        id_ex_d.alu_op = ALU_XOR;
        id_ex_d.reg_wr = 1'b1;
      end
      OP_LW: begin
        id_ex_d.alu_op     = ALU_ADDR;
        id_ex_d.src2       = '0;                                      // rt is the offset
        id_ex_d.imm        = {{(DATA_W-5){ins.r.rt[3]}}, ins.r.rt, 1'b0};  // Word offset
        id_ex_d.reg_wr     = 1'b1;
        id_ex_d.mem_en     = 1'b1;
        id_ex_d.mem_to_reg = 1'b1;
      end
      OP_SW: begin
        id_ex_d.alu_op = ALU_ADDR;
        id_ex_d.src2   = ins.r.rd;   // Store data comes from the rd field
        id_ex_d.imm    = {{(DATA_W-5){ins.r.rt[3]}}, ins.r.rt, 1'b0};
        id_ex_d.mem_en = 1'b1;
        id_ex_d.mem_wr = 1'b1;
      end
      OP_LLB, OP_LHB: begin
        id_ex_d.alu_op = (ins.i.opcode == OP_LLB) ? ALU_LLB : ALU_LHB;
        id_ex_d.src1   = '0;
        id_ex_d.src2   = ins.i.rd;   // Keeps the other byte of rd
        id_ex_d.imm    = {8'h00, ins.i.imm};
        id_ex_d.reg_wr = 1'b1;
      end
      OP_HLT: begin
        id_ex_d.src1 = '0;
        id_ex_d.src2 = '0;
        id_ex_d.halt = 1'b1;
      end
      default: begin                 // Reserved opcode runs as a no-op
        id_ex_d.src1 = '0;
        id_ex_d.src2 = '0;
      end
    endcase
    if (id_ex_d.rd == '0)
      id_ex_d.reg_wr = 1'b0;         // Writes to r0 are dropped here
  end

  // Operand read with write-back bypass
  register_file u_regs (
    .clk      (clk),
    .rst      (rst),
    .rd_idx1  (id_ex_d.src1),
    .rd_idx2  (id_ex_d.src2),
    .wb       (wb),
    .rd_data1 (rd_data1),
    .rd_data2 (rd_data2)
  );

  ////////////////////
  // Hazards
  ////////////////////
  assign load_use = id_ex.mem_to_reg && id_ex.reg_wr &&
                    (((id_ex_d.src1 != '0) && (id_ex_d.src1 == id_ex.rd)) ||
                     ((id_ex_d.src2 != '0) && (id_ex_d.src2 == id_ex.rd)));

  assign halt_seen = (ins.r.opcode == OP_HLT);

  assign bubble = load_use | halt_passed;   // HLT goes down once only

  // ID/EX register clears its enables on reset or bubble
  always_ff @(posedge clk) begin
    id_ex     <= id_ex_d;
    id_ex.op1 <= rd_data1;   // Operand values from the register file
    id_ex.op2 <= rd_data2;
    if (rst || bubble) begin
      id_ex.reg_wr     <= 1'b0;
      id_ex.mem_en     <= 1'b0;
      id_ex.mem_wr     <= 1'b0;
      id_ex.mem_to_reg <= 1'b0;
      id_ex.halt       <= 1'b0;
    end
    if (rst)
      halt_passed <= 1'b0;
    else if (id_ex_d.halt && !bubble)
      halt_passed <= 1'b1;   // Sticky until reset
  end

endmodule

`default_nettype wire

// File: design/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rd_idx1,   // Source 1 index
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rd_idx2,   // Source 2 index
  input  cpu_pkg::wb_t                   wb,        // Write port from write-back
  output logic [cpu_pkg::DATA_W-1:0]     rd_data1,
  output logic [cpu_pkg::DATA_W-1:0]     rd_data2
);

  import cpu_pkg::*;

  logic [DATA_W-1:0] regs [2**REG_ADDR_W];

  // Same-cycle write shows through and r0 reads zero
  function automatic logic [DATA_W-1:0] read_port(input logic [REG_ADDR_W-1:0] idx);
    if (idx == '0)
      return '0;
    if (wb.we && (wb.rd == idx))
      return wb.data;          // Bypass the value being written
    return regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < 2**REG_ADDR_W; k++)
        regs[k] <= '0;
    end else if (wb.we && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.data;  // r0 never stored
    end
  end

  always_comb begin
    rd_data1 = read_port(rd_idx1);
    rd_data2 = read_port(rd_idx2);
  end

endmodule

`default_nettype wire

// File: design/pipeline_control.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_control #(
  parameter logic [cpu_pkg::DATA_W-1:0] RESET_PC = '0
) (
  input  logic                       clk,        // System clock
  input  logic                       rst,        // Synchronous, active high
  input  cpu_pkg::instr_u            imem_data,  // Word at pc, same cycle
  input  logic                       load_use,   // Hold for one bubble
  input  logic                       halt_seen,  // HLT sits in IF/ID
  output logic [cpu_pkg::DATA_W-1:0] pc,
  output cpu_pkg::if_id_t            if_id
);

  import cpu_pkg::*;

  logic hlt_fetched;   // Word now at pc is HLT
  logic freeze;        // Front end holds this cycle
  logic [DATA_W-1:0] pc_next;

  ////////////////////
  // Front-end control
  ////////////////////
  // PC parks on the HLT address so it reads back as the stop point
  assign hlt_fetched = (imem_data.r.opcode == OP_HLT);

  // Stall and halt share one freeze path
  assign freeze = load_use | halt_seen;

  assign pc_next = hlt_fetched ? pc : pc + DATA_W'(2);  // No branches, always sequential

  ////////////////////
  // PC and IF/ID
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      pc    <= RESET_PC;
      if_id <= '0;            // ADD r0,r0,r0 decodes with no enables
    end else if (!freeze) begin
      pc          <= pc_next;
      if_id.instr <= imem_data;
      if_id.pc    <= pc;      // Tag word with its fetch address
    end
  end

  // While frozen, both hold and the same word is decoded again

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
package cpu_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int DATA_W     = 16;  // Data and address width
  localparam int REG_ADDR_W = 4;   // Sixteen general registers

  // Opcodes in bits 15:12, anything else runs as a no-op
  typedef enum logic [3:0] {
    OP_ADD = 4'h0,
    OP_SUB = 4'h1,
    OP_XOR = 4'h2,
    OP_LW  = 4'h8,
    OP_SW  = 4'h9,
    OP_LLB = 4'hA,
    OP_LHB = 4'hB,
    OP_HLT = 4'hF
  } opcode_e;

  // Register form, LW and SW carry a signed word offset in rt
  typedef struct packed {
    opcode_e                opcode;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
  } instr_reg_t;

  // Immediate form for LLB and LHB
  typedef struct packed {
    opcode_e                opcode;
    logic [REG_ADDR_W-1:0] rd;
    logic [7:0]             imm;
  } instr_imm_t;

  typedef union packed {
    instr_reg_t r;
    instr_imm_t i;
  } instr_u;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_LLB,   // Replace low byte of operand 2
    ALU_LHB,   // Replace high byte of operand 2
    ALU_ADDR   // Base plus scaled offset
  } alu_op_e;

  ////////////////////
  // Pipeline registers
  ////////////////////
  typedef struct packed {
    instr_u              instr;
    logic [DATA_W-1:0] pc;     // Address the word came from
  } if_id_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] src1;
    logic [REG_ADDR_W-1:0] src2;
    logic [DATA_W-1:0]     op1;
    logic [DATA_W-1:0]     op2;
    logic [DATA_W-1:0]     imm;       // Sign-extended offset or zero-extended byte
    alu_op_e               alu_op;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_wr;
    logic                  mem_en;
    logic                  mem_wr;
    logic                  mem_to_reg;
    logic                  halt;
  } id_ex_t;

  typedef struct packed {
    logic [DATA_W-1:0]     result;      // ALU value or data address
    logic [DATA_W-1:0]     store_data;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_wr;
    logic                  mem_en;
    logic                  mem_wr;
    logic                  mem_to_reg;
    logic                  halt;
  } ex_mem_t;

  typedef struct packed {
    logic [DATA_W-1:0]     result;
    logic [DATA_W-1:0]     load_data;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_wr;
    logic                  mem_to_reg;
    logic                  halt;
  } mem_wb_t;

  // Write-back bus, seen by the register file and the forwarding muxes
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] rd;
    logic [DATA_W-1:0]     data;
  } wb_t;

endpackage
